/* rtl/id_pkg.sv */
`default_nettype none

package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [4:0] {
        ALU_NOP,
        ADD, SUB, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA, LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SRC_A_RS,
        SRC_A_RT
    } src_a_sel_t;

    typedef enum logic [2:0] {
        SRC_B_NOP,
        SRC_B_RT,
        SRC_B_RS,
        SRC_B_IMM,
        SRC_B_SA
    } src_b_sel_t;

    // RES_PC_8 is the link address
    typedef enum logic [1:0] {
        RES_ALU,
        RES_PC_8
    } res_sel_t;

    typedef enum logic [3:0] {
        LS_NOP,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    } ls_sel_t;

    typedef enum logic [3:0] {
        BR_NONE,
        BEQ, BNE, BGEZ, BGTZ,
        BLEZ, BLTZ, BGEZAL, BLTZAL
    } branch_sel_t;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EX,
        FWD_MEM
    } fwd_sel_t;

    // opcode field
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LB      = 6'h20;
    localparam logic [5:0] OP_LH      = 6'h21;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_LBU     = 6'h24;
    localparam logic [5:0] OP_LHU     = 6'h25;
    localparam logic [5:0] OP_SB      = 6'h28;
    localparam logic [5:0] OP_SH      = 6'h29;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function field of SPECIAL
    localparam logic [5:0] FN_SLL     = 6'h00;
    localparam logic [5:0] FN_SRL     = 6'h02;
    localparam logic [5:0] FN_SRA     = 6'h03;
    localparam logic [5:0] FN_SLLV    = 6'h04;
    localparam logic [5:0] FN_SRLV    = 6'h06;
    localparam logic [5:0] FN_SRAV    = 6'h07;
    localparam logic [5:0] FN_JR      = 6'h08;
    localparam logic [5:0] FN_JALR    = 6'h09;
    localparam logic [5:0] FN_SYSCALL = 6'h0c;
    localparam logic [5:0] FN_BREAK   = 6'h0d;
    localparam logic [5:0] FN_ADD     = 6'h20;
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUB     = 6'h22;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_XOR     = 6'h26;
    localparam logic [5:0] FN_NOR     = 6'h27;
    localparam logic [5:0] FN_SLT     = 6'h2a;
    localparam logic [5:0] FN_SLTU    = 6'h2b;

    // rt field of REGIMM branches
    localparam logic [4:0] RT_BLTZ    = 5'h00;
    localparam logic [4:0] RT_BGEZ    = 5'h01;
    localparam logic [4:0] RT_BLTZAL  = 5'h10;
    localparam logic [4:0] RT_BGEZAL  = 5'h11;

endpackage

`default_nettype wire

/* rtl/ctrl_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode
    import id_pkg::*;
(
    input  inst_t       inst,
    input  logic        in_valid,
    output alu_op_t     alu_op,
    output src_a_sel_t  src_a_sel,
    output src_b_sel_t  src_b_sel,
    output res_sel_t    res_sel,
    output word_t       ext_imm,
    output ls_sel_t     ls_sel,
    output logic        wb_from_mem,
    output logic        w_reg_ena,
    output reg_addr_t   w_reg_dst,
    output branch_sel_t branch_sel,
    output logic        is_j_imm,
    output logic        is_jr,
    output logic        is_check_ov,
    output logic        is_syscall,
    output logic        is_break,
    output logic        is_ri
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic       sign_ext;
    logic       known;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    assign ext_imm = sign_ext ? {{16{inst[15]}}, inst[15:0]} : {16'h0000, inst[15:0]};
    assign is_ri   = in_valid & ~known;

    always_comb begin
        alu_op      = ALU_NOP;
        src_a_sel   = SRC_A_RS;
        src_b_sel   = SRC_B_NOP;
        res_sel     = RES_ALU;
        sign_ext    = 1'b0;
        ls_sel      = LS_NOP;
        wb_from_mem = 1'b0;
        w_reg_ena   = 1'b0;
        w_reg_dst   = rt;
        branch_sel  = BR_NONE;
        is_j_imm    = 1'b0;
        is_jr       = 1'b0;
        is_check_ov = 1'b0;
        is_syscall  = 1'b0;
        is_break    = 1'b0;
        known       = 1'b1;

        case (opcode)
            OP_SPECIAL: begin
                w_reg_dst   = rd;
                is_check_ov = (funct == FN_ADD) || (funct == FN_SUB);
                case (funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR: begin
                        src_b_sel = SRC_B_RT;
                        w_reg_ena = 1'b1;
                    end
                    // word 0 (nop) lands here as sll into $0
                    FN_SLL, FN_SRL, FN_SRA: begin
                        src_a_sel = SRC_A_RT;
                        src_b_sel = SRC_B_SA;
                        w_reg_ena = 1'b1;
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                        src_a_sel = SRC_A_RT;
                        src_b_sel = SRC_B_RS;
                        w_reg_ena = 1'b1;
                    end
                    FN_JR: is_jr = 1'b1;
                    FN_JALR: begin
                        is_jr     = 1'b1;
                        res_sel   = RES_PC_8;
                        w_reg_ena = 1'b1;
                    end
                    FN_SYSCALL: is_syscall = 1'b1;
                    FN_BREAK:   is_break   = 1'b1;
                    default:    known      = 1'b0;
                endcase
                case (funct)
                    FN_ADD, FN_ADDU:  alu_op = ADD;
                    FN_SUB, FN_SUBU:  alu_op = SUB;
                    FN_SLT:           alu_op = SLT;
                    FN_SLTU:          alu_op = SLTU;
                    FN_AND:           alu_op = AND;
                    FN_OR:            alu_op = OR;
                    FN_XOR:           alu_op = XOR;
                    FN_NOR:           alu_op = NOR;
                    FN_SLL, FN_SLLV:  alu_op = SLL;
                    FN_SRL, FN_SRLV:  alu_op = SRL;
                    FN_SRA, FN_SRAV:  alu_op = SRA;
                    default:          alu_op = ALU_NOP;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                src_b_sel   = SRC_B_IMM;
                w_reg_ena   = 1'b1;
                is_check_ov = (opcode == OP_ADDI);
                // 08..0b are the arithmetic forms, 0c..0f the logical ones
                sign_ext    = ~opcode[2];
                case (opcode)
                    OP_ADDI, OP_ADDIU: alu_op = ADD;
                    OP_SLTI:           alu_op = SLT;
                    OP_SLTIU:          alu_op = SLTU;
                    OP_ANDI:           alu_op = AND;
                    OP_ORI:            alu_op = OR;
                    OP_XORI:           alu_op = XOR;
                    default:           alu_op = LUI;
                endcase
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                alu_op      = ADD;
                src_b_sel   = SRC_B_IMM;
                sign_ext    = 1'b1;
                wb_from_mem = 1'b1;
                w_reg_ena   = 1'b1;
                case (opcode)
                    OP_LB:   ls_sel = LB;
                    OP_LBU:  ls_sel = LBU;
                    OP_LH:   ls_sel = LH;
                    OP_LHU:  ls_sel = LHU;
                    default: ls_sel = LW;
                endcase
            end
            OP_SB, OP_SH, OP_SW: begin
                alu_op    = ADD;
                src_b_sel = SRC_B_IMM;
                sign_ext  = 1'b1;
                case (opcode)
                    OP_SB:   ls_sel = SB;
                    OP_SH:   ls_sel = SH;
                    default: ls_sel = SW;
                endcase
            end
            OP_BEQ:  branch_sel = BEQ;
            OP_BNE:  branch_sel = BNE;
            OP_BLEZ: branch_sel = BLEZ;
            OP_BGTZ: branch_sel = BGTZ;
            OP_REGIMM: begin
                case (rt)
                    RT_BLTZ:   branch_sel = BLTZ;
                    RT_BGEZ:   branch_sel = BGEZ;
                    RT_BLTZAL: branch_sel = BLTZAL;
                    RT_BGEZAL: branch_sel = BGEZAL;
                    default:   known      = 1'b0;
                endcase
                // and-link forms also write $31
                if (rt == RT_BLTZAL || rt == RT_BGEZAL) begin
                    res_sel   = RES_PC_8;
                    w_reg_ena = 1'b1;
                    w_reg_dst = 5'd31;
                end
            end
            OP_J: is_j_imm = 1'b1;
            OP_JAL: begin
                is_j_imm  = 1'b1;
                res_sel   = RES_PC_8;
                w_reg_ena = 1'b1;
                w_reg_dst = 5'd31;
            end
            default: known = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/operand_read.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_read
    import id_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  fwd_sel_t  fwd_rs,
    input  fwd_sel_t  fwd_rt,
    input  word_t     ex_result,
    input  word_t     mem_result,
    output word_t     rs_data,
    output word_t     rt_data
);

    localparam int IDX_W = $clog2(REG_COUNT);

    word_t regs [REG_COUNT];
    word_t rs_reg;
    word_t rt_reg;

    // $0 and indices past a reduced register set are not backed by storage
    function automatic logic in_range(reg_addr_t a);
        return (a != 5'd0) && (int'(a) < REG_COUNT);
    endfunction

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t ex_val,
                                      word_t mem_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            default: return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && in_range(wb_addr)) begin
            regs[wb_addr[IDX_W-1:0]] <= wb_data;
        end
    end

    // same-cycle write is not bypassed here
    assign rs_reg = in_range(rs_addr) ? regs[rs_addr[IDX_W-1:0]] : '0;
    assign rt_reg = in_range(rt_addr) ? regs[rt_addr[IDX_W-1:0]] : '0;

    assign rs_data = fwd_mux(fwd_rs, rs_reg, ex_result, mem_result);
    assign rt_data = fwd_mux(fwd_rt, rt_reg, ex_result, mem_result);

endmodule

`default_nettype wire

/* rtl/jump_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module jump_resolve
    import id_pkg::*;
(
    input  word_t       pc,
    input  inst_t       inst,
    input  branch_sel_t branch_sel,
    input  logic        is_j_imm,
    input  logic        is_jr,
    input  word_t       rs_data,
    input  word_t       rt_data,
    output logic        take_jmp,
    output word_t       jmp_target
);

    logic signed [31:0] rs_s;
    word_t              br_offset;
    logic               br_taken;

    assign rs_s      = rs_data;
    assign br_offset = {{14{inst[15]}}, inst[15:0], 2'b00};

    always_comb begin
        case (branch_sel)
            BEQ:          br_taken = (rs_data == rt_data);
            BNE:          br_taken = (rs_data != rt_data);
            BGEZ, BGEZAL: br_taken = (rs_s >= 0);
            BGTZ:         br_taken = (rs_s > 0);
            BLEZ:         br_taken = (rs_s <= 0);
            BLTZ, BLTZAL: br_taken = (rs_s < 0);
            default:      br_taken = 1'b0;
        endcase
    end

    assign take_jmp = is_j_imm | is_jr | br_taken;

    // region jump keeps the top nibble of pc
    assign jmp_target = is_jr    ? rs_data :
                        is_j_imm ? {pc[31:28], inst[25:0], 2'b00} :
                                   pc + 32'd4 + br_offset;

endmodule

`default_nettype wire

/* rtl/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import id_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        flush,
    input  logic        in_valid,
    input  logic        in_delay_slot,
    input  word_t       pc,
    input  alu_op_t     alu_op,
    input  src_a_sel_t  src_a_sel,
    input  src_b_sel_t  src_b_sel,
    input  res_sel_t    res_sel,
    input  word_t       ext_imm,
    input  ls_sel_t     ls_sel,
    input  logic        wb_from_mem,
    input  logic        w_reg_ena,
    input  reg_addr_t   w_reg_dst,
    input  branch_sel_t branch_sel,
    input  logic        is_j_imm,
    input  logic        is_jr,
    input  logic        is_check_ov,
    input  logic        is_syscall,
    input  logic        is_break,
    input  logic        is_ri,
    input  word_t       rs_data,
    input  word_t       rt_data,
    input  logic        take_jmp,
    input  word_t       jmp_target,
    output logic        id_valid,
    output logic        id_in_delay_slot,
    output word_t       id_pc,
    output alu_op_t     id_alu_op,
    output src_a_sel_t  id_src_a_sel,
    output src_b_sel_t  id_src_b_sel,
    output res_sel_t    id_res_sel,
    output word_t       id_ext_imm,
    output ls_sel_t     id_ls_sel,
    output logic        id_wb_from_mem,
    output logic        id_w_reg_ena,
    output reg_addr_t   id_w_reg_dst,
    output branch_sel_t id_branch_sel,
    output logic        id_is_j_imm,
    output logic        id_is_jr,
    output logic        id_is_check_ov,
    output logic        id_is_syscall,
    output logic        id_is_break,
    output logic        id_is_ri,
    output word_t       id_rs_data,
    output word_t       id_rt_data,
    output logic        id_take_jmp,
    output word_t       id_jmp_target
);

    // flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            id_valid       <= 1'b0;
            id_ls_sel      <= LS_NOP;
            id_wb_from_mem <= 1'b0;
            id_w_reg_ena   <= 1'b0;
            id_branch_sel  <= BR_NONE;
            id_is_j_imm    <= 1'b0;
            id_is_jr       <= 1'b0;
            id_take_jmp    <= 1'b0;
            id_is_check_ov <= 1'b0;
            id_is_syscall  <= 1'b0;
            id_is_break    <= 1'b0;
            id_is_ri       <= 1'b0;
        end else if (!stall) begin
            id_valid       <= in_valid;
            // empty slot must not write, access memory or redirect
            id_ls_sel      <= in_valid ? ls_sel : LS_NOP;
            id_wb_from_mem <= wb_from_mem & in_valid;
            id_w_reg_ena   <= w_reg_ena & in_valid;
            id_branch_sel  <= in_valid ? branch_sel : BR_NONE;
            id_is_j_imm    <= is_j_imm & in_valid;
            id_is_jr       <= is_jr & in_valid;
            id_take_jmp    <= take_jmp & in_valid;
            id_is_check_ov <= is_check_ov & in_valid;
            id_is_syscall  <= is_syscall & in_valid;
            id_is_break    <= is_break & in_valid;
            id_is_ri       <= is_ri;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_in_delay_slot <= in_delay_slot;
            id_pc            <= pc;
            id_alu_op        <= alu_op;
            id_src_a_sel     <= src_a_sel;
            id_src_b_sel     <= src_b_sel;
            id_res_sel       <= res_sel;
            id_ext_imm       <= ext_imm;
            id_w_reg_dst     <= w_reg_dst;
            id_rs_data       <= rs_data;
            id_rt_data       <= rt_data;
            id_jmp_target    <= jmp_target;
        end
    end

endmodule

`default_nettype wire

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import id_pkg::*;
#(
    parameter int REG_COUNT = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  inst_t       inst,
    input  word_t       pc,
    input  logic        in_delay_slot,
    input  fwd_sel_t    fwd_rs,
    input  fwd_sel_t    fwd_rt,
    input  word_t       ex_result,
    input  word_t       mem_result,
    input  logic        wb_en,
    input  reg_addr_t   wb_addr,
    input  word_t       wb_data,
    input  logic        stall,
    input  logic        flush,
    output logic        id_valid,
    output logic        id_in_delay_slot,
    output word_t       id_pc,
    output alu_op_t     id_alu_op,
    output src_a_sel_t  id_src_a_sel,
    output src_b_sel_t  id_src_b_sel,
    output res_sel_t    id_res_sel,
    output word_t       id_ext_imm,
    output ls_sel_t     id_ls_sel,
    output logic        id_wb_from_mem,
    output logic        id_w_reg_ena,
    output reg_addr_t   id_w_reg_dst,
    output branch_sel_t id_branch_sel,
    output logic        id_is_j_imm,
    output logic        id_is_jr,
    output logic        id_is_check_ov,
    output logic        id_is_syscall,
    output logic        id_is_break,
    output logic        id_is_ri,
    output word_t       id_rs_data,
    output word_t       id_rt_data,
    output logic        id_take_jmp,
    output word_t       id_jmp_target
);

    alu_op_t     alu_op;
    src_a_sel_t  src_a_sel;
    src_b_sel_t  src_b_sel;
    res_sel_t    res_sel;
    word_t       ext_imm;
    ls_sel_t     ls_sel;
    logic        wb_from_mem;
    logic        w_reg_ena;
    reg_addr_t   w_reg_dst;
    branch_sel_t branch_sel;
    logic        is_j_imm;
    logic        is_jr;
    logic        is_check_ov;
    logic        is_syscall;
    logic        is_break;
    logic        is_ri;
    word_t       rs_data;
    word_t       rt_data;
    logic        take_jmp;
    word_t       jmp_target;

    ctrl_decode u_ctrl_decode (.*);

    // rs and rt fields address the register file directly
    operand_read #(
        .REG_COUNT (REG_COUNT)
    ) u_operand_read (
        .rs_addr (inst[25:21]),
        .rt_addr (inst[20:16]),
        .*
    );

    jump_resolve u_jump_resolve (.*);

    id_ex_reg u_id_ex_reg (.*);

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // released just after an edge, so the DUT sees a clean synchronous deassert
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tb_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage
    import id_pkg::*;
();

    localparam int VEC_WORDS    = 12;
    localparam int MAX_VEC      = 64;
    localparam int RESET_CYCLES = 8;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_delay_slot;
    logic        wb_en;
    logic        stall;
    logic        flush;
    inst_t       inst;
    word_t       pc;
    word_t       ex_result;
    word_t       mem_result;
    word_t       wb_data;
    reg_addr_t   wb_addr;
    fwd_sel_t    fwd_rs;
    fwd_sel_t    fwd_rt;

    logic        id_valid;
    logic        id_in_delay_slot;
    logic        id_wb_from_mem;
    logic        id_w_reg_ena;
    logic        id_is_j_imm;
    logic        id_is_jr;
    logic        id_is_check_ov;
    logic        id_is_syscall;
    logic        id_is_break;
    logic        id_is_ri;
    logic        id_take_jmp;
    word_t       id_pc;
    word_t       id_ext_imm;
    word_t       id_rs_data;
    word_t       id_rt_data;
    word_t       id_jmp_target;
    alu_op_t     id_alu_op;
    src_a_sel_t  id_src_a_sel;
    src_b_sel_t  id_src_b_sel;
    res_sel_t    id_res_sel;
    ls_sel_t     id_ls_sel;
    reg_addr_t   id_w_reg_dst;
    branch_sel_t id_branch_sel;

    word_t vec_mem [VEC_WORDS*MAX_VEC];
    int    n_vec;
    int    errors;
    int    cycles;
    int    cycle_limit;
    int    seed;

    // what the pipeline register last captured
    inst_t held_inst;
    word_t held_pc;
    logic  held_valid;
    logic  held_delay_slot;

    tb_clock_gen u_clock_gen (.clk(clk), .reset(reset));

    id_stage #(.REG_COUNT(32)) DUT (.*);

    task automatic check_val(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // jump kind from the MIPS opcode, REGIMM rt and SPECIAL funct fields
    task automatic expected_jump_kind(input inst_t w, input logic valid,
                                      output branch_sel_t br, output logic j_imm,
                                      output logic jr);
        br    = BR_NONE;
        j_imm = 1'b0;
        jr    = 1'b0;
        if (valid) begin
            case (w[31:26])
                6'h00: jr = (w[5:0] == 6'h08) || (w[5:0] == 6'h09);
                6'h01: begin
                    case (w[20:16])
                        5'h00:   br = BLTZ;
                        5'h01:   br = BGEZ;
                        5'h10:   br = BLTZAL;
                        5'h11:   br = BGEZAL;
                        default: br = BR_NONE;
                    endcase
                end
                6'h02, 6'h03: j_imm = 1'b1;
                6'h04: br = BEQ;
                6'h05: br = BNE;
                6'h06: br = BLEZ;
                6'h07: br = BGTZ;
                default: br = BR_NONE;
            endcase
        end
    endtask

    task automatic apply_vector(input int idx);
        int    base;
        word_t ctl;
        base = idx * VEC_WORDS;
        ctl  = vec_mem[base];
        in_valid = ctl[23];
        stall    = ctl[22];
        flush    = ctl[21];
        wb_en    = ctl[20];
        fwd_rs   = fwd_sel_t'(ctl[17:16]);
        fwd_rt   = fwd_sel_t'(ctl[13:12]);
        wb_addr  = ctl[4:0];
        inst     = vec_mem[base+1];
        pc       = vec_mem[base+2];
        wb_data  = vec_mem[base+5];
        // delay-slot flag alternates so both values pass through
        in_delay_slot = idx[0];
        // values no mux selects get random filler
        if (fwd_rs == FWD_EX || fwd_rt == FWD_EX)
            ex_result = vec_mem[base+3];
        else
            ex_result = $random(seed);
        if (fwd_rs == FWD_MEM || fwd_rt == FWD_MEM)
            mem_result = vec_mem[base+4];
        else
            mem_result = $random(seed);
        if (!stall) begin
            held_inst       = inst;
            held_pc         = pc;
            held_valid      = in_valid;
            held_delay_slot = in_delay_slot;
        end
    endtask

    task automatic compare_outputs(input int idx);
        int          base;
        logic [7:0]  mask;
        word_t       dec;
        word_t       flg;
        string       tag;
        branch_sel_t exp_br;
        logic        exp_j_imm;
        logic        exp_jr;
        base = idx * VEC_WORDS;
        mask = vec_mem[base][31:24];
        dec  = vec_mem[base+6];
        flg  = vec_mem[base+7];
        tag  = $sformatf("vector %0d", idx);
        if (mask[0])
            check_val({tag, " id_valid"}, 32'(flg[28]), 32'(id_valid));
        if (!vec_mem[base][21]) begin
            check_val({tag, " id_pc"}, held_pc, id_pc);
            check_val({tag, " id_in_delay_slot"}, 32'(held_delay_slot),
                      32'(id_in_delay_slot));
        end
        if (mask[1]) begin
            check_val({tag, " id_rs_data"}, vec_mem[base+9], id_rs_data);
            check_val({tag, " id_rt_data"}, vec_mem[base+10], id_rt_data);
        end
        if (mask[2]) begin
            check_val({tag, " id_alu_op"}, 32'(dec[31:24]), 32'(id_alu_op));
            check_val({tag, " id_src_a_sel"}, 32'(dec[23:20]), 32'(id_src_a_sel));
            check_val({tag, " id_src_b_sel"}, 32'(dec[19:16]), 32'(id_src_b_sel));
            check_val({tag, " id_res_sel"}, 32'(dec[15:12]), 32'(id_res_sel));
            check_val({tag, " id_ls_sel"}, 32'(dec[11:8]), 32'(id_ls_sel));
            check_val({tag, " id_w_reg_dst"}, 32'(dec[7:0]), 32'(id_w_reg_dst));
            check_val({tag, " id_w_reg_ena"}, 32'(flg[24]), 32'(id_w_reg_ena));
            check_val({tag, " id_wb_from_mem"}, 32'(flg[20]), 32'(id_wb_from_mem));
        end
        if (mask[3]) begin
            expected_jump_kind(held_inst, held_valid, exp_br, exp_j_imm, exp_jr);
            check_val({tag, " id_take_jmp"}, 32'(flg[16]), 32'(id_take_jmp));
            check_val({tag, " id_jmp_target"}, vec_mem[base+11], id_jmp_target);
            check_val({tag, " id_branch_sel"}, 32'(exp_br), 32'(id_branch_sel));
            check_val({tag, " id_is_j_imm"}, 32'(exp_j_imm), 32'(id_is_j_imm));
            check_val({tag, " id_is_jr"}, 32'(exp_jr), 32'(id_is_jr));
        end
        if (mask[4]) begin
            check_val({tag, " id_is_check_ov"}, 32'(flg[12]), 32'(id_is_check_ov));
            check_val({tag, " id_is_syscall"}, 32'(flg[8]), 32'(id_is_syscall));
            check_val({tag, " id_is_break"}, 32'(flg[4]), 32'(id_is_break));
            check_val({tag, " id_is_ri"}, 32'(flg[0]), 32'(id_is_ri));
        end
        if (mask[5])
            check_val({tag, " id_ext_imm"}, vec_mem[base+8], id_ext_imm);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("errors: %0d", errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        seed            = 32'h50c5;
        errors          = 0;
        cycles          = 0;
        cycle_limit     = 0;
        n_vec           = 0;
        held_inst       = '0;
        held_pc         = '0;
        held_valid      = 1'b0;
        held_delay_slot = 1'b0;
        in_valid        = 1'b0;
        in_delay_slot   = 1'b0;
        wb_en           = 1'b0;
        stall           = 1'b0;
        flush           = 1'b0;
        inst            = '0;
        pc              = '0;
        ex_result       = '0;
        mem_result      = '0;
        wb_data         = '0;
        wb_addr         = '0;
        fwd_rs          = FWD_REG;
        fwd_rt          = FWD_REG;

        $readmemh("dv/id_testdata.hex", vec_mem);
        // all-ones control word ends the vector list
        while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_WORDS] !== 32'hffffffff)
            n_vec++;
        cycle_limit = (n_vec + RESET_CYCLES) * 4;
        if (n_vec == 0) begin
            errors++;
            $display("no test vectors were loaded from dv/id_testdata.hex");
        end

        @(negedge reset);
        check_val("reset id_valid", 32'd0, 32'(id_valid));
        check_val("reset id_take_jmp", 32'd0, 32'(id_take_jmp));
        check_val("reset id_ls_sel", 32'(LS_NOP), 32'(id_ls_sel));
        check_val("reset id_w_reg_ena", 32'd0, 32'(id_w_reg_ena));
        check_val("reset id_is_ri", 32'd0, 32'(id_is_ri));

        for (int i = 0; i < n_vec; i++) begin
            apply_vector(i);
            @(posedge clk);
            #2;
            compare_outputs(i);
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/id_pkg.sv
rtl/ctrl_decode.sv
rtl/operand_read.sv
rtl/jump_resolve.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
dv/tb_clock_gen.sv
dv/tb_id_stage.sv

/* run_sim.sh */
#!/bin/sh
# builds the id_stage testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_id_stage -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* dv/id_testdata.hex */
// ctl inst pc ex_result mem_result wb_data exp_dec exp_flags exp_imm exp_rs exp_rt exp_target
// ctl: mask[31:24] {in_valid,stall,flush,wb_en}[23:20] fwd_rs[19:16] fwd_rt[15:12] wb_addr[7:0]
// mask: 01 valid, 02 operands, 04 decode, 08 jump, 10 exception flags, 20 ext_imm
// exp_dec: alu_op src_a src_b res ls dst; exp_flags: valid wen mem jmp ov sys brk ri
11900001 0000000c 00000000 00000000 00000000 11111111 00000000 10000100 00000000 00000000 00000000 00000000
11900002 0000000d 00000004 00000000 00000000 22222222 00000000 10000010 00000000 00000000 00000000 00000000
11900003 fc000000 00000008 00000000 00000000 80000000 00000000 10000001 00000000 00000000 00000000 00000000
11100000 fc000000 0000000c 00000000 00000000 deadbeef 00000000 00000000 00000000 00000000 00000000 00000000
17800000 00222820 00400000 00000000 00000000 00000000 01010005 11001000 00000000 11111111 22222222 00000000
17800000 00603025 00400004 00000000 00000000 00000000 06010006 11000000 00000000 80000000 00000000 00000000
15800000 00223821 00400008 00000000 00000000 00000000 01010007 11000000 00000000 00000000 00000000 00000000
03812000 00224020 0040000c aaaa5555 0f0f0f0f 00000000 00000000 10000000 00000000 aaaa5555 0f0f0f0f 00000000
35800000 202afffc 00400010 00000000 00000000 00000000 0103000a 11001000 fffffffc 00000000 00000000 00000000
35800000 304b8001 00400014 00000000 00000000 00000000 0503000b 11000000 00008001 00000000 00000000 00000000
35800000 286c8000 00400018 00000000 00000000 00000000 0303000c 11000000 ffff8000 00000000 00000000 00000000
35800000 3c0d1234 0040001c 00000000 00000000 00000000 0c03000d 11000000 00001234 00000000 00000000 00000000
15800000 000270c0 00400020 00000000 00000000 00000000 0914000e 11000000 00000000 00000000 00000000 00000000
17800000 00227807 00400024 00000000 00000000 00000000 0b12000f 11000000 00000000 11111111 22222222 00000000
35800000 8c300008 00400028 00000000 00000000 00000000 01030510 11100000 00000008 00000000 00000000 00000000
35800000 a022ffff 0040002c 00000000 00000000 00000000 01030602 10000000 ffffffff 00000000 00000000 00000000
19800000 10210004 00400100 00000000 00000000 00000000 00000000 10010000 00000000 00000000 00000000 00400114
19800000 1022fffe 00400200 00000000 00000000 00000000 00000000 10000000 00000000 00000000 00000000 004001fc
19800000 14220001 00400300 00000000 00000000 00000000 00000000 10010000 00000000 00000000 00000000 00400308
19800000 14420001 00400400 00000000 00000000 00000000 00000000 10000000 00000000 00000000 00000000 00400408
19800000 04600008 00400500 00000000 00000000 00000000 00000000 10010000 00000000 00000000 00000000 00400524
19800000 04200008 00400600 00000000 00000000 00000000 00000000 10000000 00000000 00000000 00000000 00400624
19800000 04210008 00400700 00000000 00000000 00000000 00000000 10010000 00000000 00000000 00000000 00400724
19800000 04610008 00400800 00000000 00000000 00000000 00000000 10000000 00000000 00000000 00000000 00400824
19800000 08123456 9fc00010 00000000 00000000 00000000 00000000 10010000 00000000 00000000 00000000 9048d158
1d800000 0c000040 00400900 00000000 00000000 00000000 0000101f 11010000 00000000 00000000 00000000 00000100
19800000 00400008 00400a00 00000000 00000000 00000000 00000000 10010000 00000000 00000000 00000000 22222222
1bd00014 1022fffe 00400b00 00000000 00000000 13579bdf 00000000 10010000 00000000 22222222 00000000 22222222
11e00000 0000000c 00400c00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
03800000 0280a825 00400d00 00000000 00000000 00000000 00000000 10000000 00000000 13579bdf 00000000 00000000
ffffffff 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
